// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_frontend_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/decode_frontend.sv
/*
 * decode front end top: instruction buffer and two decode slots
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_frontend
  import decode_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic                             wr_valid_i,
  input  logic [1:0]                       wr_num_i,
  input  fetch_entry_t [`FETCH_WIDTH-1:0]  wr_data_i,
  output logic                             wr_ready_o,
  output logic [`DECODE_WIDTH-1:0]         dec_valid_o,
  output decoded_t [`DECODE_WIDTH-1:0]     dec_o,
  input  logic                             dec_ready_i
);

  fetch_entry_t [`DECODE_WIDTH-1:0] head;

  // ============================================================
  // instruction buffer
  // ============================================================
  inst_buffer #(
    .DEPTH (`IBUF_DEPTH)
  ) u_inst_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wr_valid_i (wr_valid_i),
    .wr_num_i   (wr_num_i),
    .wr_data_i  (wr_data_i),
    .wr_ready_o (wr_ready_o),
    .rd_valid_o (dec_valid_o),
    .rd_data_o  (head),
    .rd_ready_i (dec_ready_i)
  );

  // ============================================================
  // decode slots, slot 0 is the oldest
  // ============================================================
  for (genvar k = 0; k < `DECODE_WIDTH; k++) begin : g_slot
    logic [`AREG_W-1:0] src0;
    logic [`AREG_W-1:0] src1;
    logic [`AREG_W-1:0] dest;
    logic [`XLEN-1:0]   imm;
    priv_op_e           priv_op;

    operand_decoder u_operand_decoder (
      .entry_i   (head[k]),
      .src0_o    (src0),
      .src1_o    (src1),
      .dest_o    (dest),
      .priv_op_o (priv_op)
    );

    imm_extender u_imm_extender (
      .instr_i    (head[k].instr),
      .imm_type_i (head[k].imm_type),
      .pc_i       (head[k].pc),
      .imm_o      (imm)
    );

    assign dec_o[k] = '{pc: head[k].pc, instr: head[k].instr, src0: src0, src1: src1,
                        dest: dest, imm: imm, priv_op: priv_op};
  end

endmodule

`default_nettype wire

// File: hdl/decode_macros.svh
/*
 * decode front end widths, buffer depth and architectural register constants
 */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// ============================================================
// pipeline widths
// ============================================================
`define FETCH_WIDTH   2
`define DECODE_WIDTH  2
// must stay a power of two
`define IBUF_DEPTH    8

// ============================================================
// data and register widths
// ============================================================
`define XLEN          32
`define AREG_W        5

// ============================================================
// fixed register numbers and csr rj codes
// ============================================================
`define REG_RA        5'd1
`define CSR_RJ_READ   5'd0
`define CSR_RJ_WRITE  5'd1

`endif

// File: hdl/decode_pkg.sv
/*
 * decode types: instruction word views, pre-decode enums,
 * fetched and decoded entry structs
 */
`default_nettype none
`include "decode_macros.svh"

package decode_pkg;

  // ============================================================
  // instruction word
  // ============================================================
  // register field view, rd in the lowest bits
  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } instr_reg_t;

  // immediate source view, 26 bits below the major opcode
  typedef struct packed {
    logic [5:0]  major_op;
    logic [25:0] src;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t reg_view;
    instr_imm_t imm_view;
  } instr_u;

  // ============================================================
  // pre-decode classes
  // ============================================================
  typedef enum logic [1:0] {
    SRC_R0 = 2'd0,
    SRC_RD = 2'd1,
    SRC_RJ = 2'd2,
    SRC_RK = 2'd3
  } src_type_e;

  typedef enum logic [1:0] {
    DEST_R0 = 2'd0,
    DEST_RD = 2'd1,
    DEST_JD = 2'd2,
    DEST_RA = 2'd3
  } dest_type_e;

  typedef enum logic [3:0] {
    IMM_NONE = 4'd0,
    IMM_UI5  = 4'd1,
    IMM_UI12 = 4'd2,
    IMM_SI12 = 4'd3,
    IMM_SI14 = 4'd4,
    IMM_SI16 = 4'd5,
    IMM_SI20 = 4'd6,
    IMM_SI26 = 4'd7,
    IMM_PC   = 4'd8
  } imm_type_e;

  typedef enum logic [2:0] {
    PRIV_NONE      = 3'd0,
    PRIV_CSR_XCHG  = 3'd1,
    PRIV_CSR_READ  = 3'd2,
    PRIV_CSR_WRITE = 3'd3,
    PRIV_RDCNTVL   = 3'd4,
    PRIV_RDCNTID   = 3'd5
  } priv_op_e;

  // ============================================================
  // buffer entry and decoded slot
  // ============================================================
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    instr_u           instr;
    src_type_e        src0_type;
    src_type_e        src1_type;
    dest_type_e       dest_type;
    imm_type_e        imm_type;
    priv_op_e         priv_op;
  } fetch_entry_t;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    instr_u             instr;
    logic [`AREG_W-1:0] src0;
    logic [`AREG_W-1:0] src1;
    logic [`AREG_W-1:0] dest;
    logic [`XLEN-1:0]   imm;
    priv_op_e           priv_op;
  } decoded_t;

endpackage

`default_nettype wire

// File: hdl/imm_extender.sv
/*
 * immediate field extraction and sign, zero or pc-relative extension
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module imm_extender
  import decode_pkg::*;
(
  input  instr_u           instr_i,
  input  imm_type_e        imm_type_i,
  input  logic [`XLEN-1:0] pc_i,
  output logic [`XLEN-1:0] imm_o
);

  logic [25:0]      src;
  logic [`XLEN-1:0] si20;

  assign src  = instr_i.imm_view.src;
  // shared by lu12i style and pc-relative forms
  assign si20 = {{(`XLEN-20){src[24]}}, src[24:5]};

  always_comb begin
    case (imm_type_i)
      IMM_UI5:  imm_o = {{(`XLEN-5){1'b0}}, src[14:10]};
      IMM_UI12: imm_o = {{(`XLEN-12){1'b0}}, src[21:10]};
      IMM_SI12: imm_o = {{(`XLEN-12){src[21]}}, src[21:10]};
      IMM_SI14: imm_o = {{(`XLEN-14){src[23]}}, src[23:10]};
      IMM_SI16: imm_o = {{(`XLEN-16){src[25]}}, src[25:10]};
      IMM_SI20: imm_o = si20;
      // branch offset, low field holds the upper bits
      IMM_SI26: imm_o = {{(`XLEN-26){src[9]}}, src[9:0], src[25:10]};
      IMM_PC:   imm_o = pc_i + si20;
      default:  imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/inst_buffer.sv
/*
 * circular instruction buffer, up to FETCH_WIDTH writes and
 * DECODE_WIDTH reads per cycle, with flush
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module inst_buffer
  import decode_pkg::*;
#(
  parameter int DEPTH = `IBUF_DEPTH
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic                             wr_valid_i,
  input  logic [1:0]                       wr_num_i,
  input  fetch_entry_t [`FETCH_WIDTH-1:0]  wr_data_i,
  output logic                             wr_ready_o,
  output logic [`DECODE_WIDTH-1:0]         rd_valid_o,
  output fetch_entry_t [`DECODE_WIDTH-1:0] rd_data_o,
  input  logic                             rd_ready_i
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  fetch_entry_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_cnt;
  logic [CNT_W-1:0] push_num;
  logic [CNT_W-1:0] pop_num;
  logic             wr_fire;

  // ============================================================
  // write side
  // ============================================================
  assign free_cnt   = CNT_W'(DEPTH) - count;
  // room for a full fetch group
  assign wr_ready_o = free_cnt >= CNT_W'(`FETCH_WIDTH);
  // a write in the flush cycle is dropped
  assign wr_fire    = wr_valid_i & wr_ready_o & ~flush_i;
  assign push_num   = wr_fire ? CNT_W'(wr_num_i) : '0;

  // ============================================================
  // read side
  // ============================================================
  // slot k sees the k-th oldest entry, reads wrap with the pointer
  always_comb begin
    pop_num = '0;
    for (int k = 0; k < `DECODE_WIDTH; k++) begin
      rd_valid_o[k] = count > CNT_W'(k);
      rd_data_o[k]  = mem[rd_ptr + PTR_W'(k)];
      if (rd_ready_i && rd_valid_o[k]) begin
        pop_num = pop_num + CNT_W'(1);
      end
    end
  end

  // ============================================================
  // pointers and occupancy
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + push_num[PTR_W-1:0];
      rd_ptr <= rd_ptr + pop_num[PTR_W-1:0];
      count  <= count + push_num - pop_num;
    end
  end

  // entry storage
  // slots 0 .. wr_num_i-1 land at consecutive positions
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (CNT_W'(i) < push_num) begin
          mem[wr_ptr + PTR_W'(i)] <= wr_data_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/operand_decoder.sv
/*
 * architectural register selection and privileged op refinement
 * for one decode slot
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module operand_decoder
  import decode_pkg::*;
(
  input  fetch_entry_t       entry_i,
  output logic [`AREG_W-1:0] src0_o,
  output logic [`AREG_W-1:0] src1_o,
  output logic [`AREG_W-1:0] dest_o,
  output priv_op_e           priv_op_o
);

  instr_reg_t fields;

  assign fields = entry_i.instr.reg_view;

  // pick the field a source type names
  function automatic logic [`AREG_W-1:0] sel_src(src_type_e t, instr_reg_t f);
    logic [`AREG_W-1:0] r;
    case (t)
      SRC_RD:  r = f.rd;
      SRC_RJ:  r = f.rj;
      SRC_RK:  r = f.rk;
      default: r = '0;
    endcase
    return r;
  endfunction

  // ============================================================
  // register numbers
  // ============================================================
  assign src0_o = sel_src(entry_i.src0_type, fields);
  assign src1_o = sel_src(entry_i.src1_type, fields);

  always_comb begin
    case (entry_i.dest_type)
      DEST_RD: dest_o = fields.rd;
      // jirl style link register, rj merged into rd
      DEST_JD: dest_o = fields.rj | fields.rd;
      DEST_RA: dest_o = `REG_RA;
      default: dest_o = '0;
    endcase
  end

  // ============================================================
  // privileged op refinement
  // ============================================================
  always_comb begin
    priv_op_o = entry_i.priv_op;
    case (entry_i.priv_op)
      PRIV_CSR_XCHG: begin
        if (fields.rj == `CSR_RJ_READ) begin
          priv_op_o = PRIV_CSR_READ;
        end else if (fields.rj == `CSR_RJ_WRITE) begin
          priv_op_o = PRIV_CSR_WRITE;
        end
      end
      // rdcntvl with a nonzero rj is rdcntid
      PRIV_RDCNTVL: begin
        if (fields.rj != '0) begin
          priv_op_o = PRIV_RDCNTID;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/inst_buffer.sv
hdl/operand_decoder.sv
hdl/imm_extender.sv
hdl/decode_frontend.sv
verif/tb_clock_gen.sv
verif/decode_frontend_properties.sv
verif/decode_frontend_tb.sv

// File: verif/decode_frontend_properties.sv
/*
 * bound protocol checks for the decode front end: reset and flush state,
 * write protocol, slot order and hold under back-pressure
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_frontend_properties
  import decode_pkg::*;
(
  input logic                         clk,
  input logic                         rst_n,
  input logic                         flush_i,
  input logic                         wr_valid_i,
  input logic                         wr_ready_i,
  input logic [`DECODE_WIDTH-1:0]     dec_valid_i,
  input decoded_t [`DECODE_WIDTH-1:0] dec_i,
  input logic                         dec_ready_i
);

  int fail_count = 0;

  // empty and ready right after reset release
  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> dec_valid_i == '0 && wr_ready_i)
    else begin
      $error("buffer not empty and ready after reset release");
      fail_count++;
    end

  // ============================================================
  // write side and flush
  // ============================================================
  a_write_protocol: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid_i |-> wr_ready_i)
    else begin
      $error("write strobe while the buffer is not ready");
      fail_count++;
    end

  a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> dec_valid_i == '0 && wr_ready_i)
    else begin
      $error("buffer not empty and ready in the cycle after a flush");
      fail_count++;
    end

  // ============================================================
  // read side
  // ============================================================
  // slot 1 is always the entry right after slot 0
  a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid_i[1] |-> dec_i[1].pc == dec_i[0].pc + 32'd4)
    else begin
      $error("slot 1 pc does not follow slot 0 pc");
      fail_count++;
    end

  for (genvar k = 0; k < `DECODE_WIDTH; k++) begin : g_hold
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid_i[k] && !dec_ready_i && !flush_i |=> dec_valid_i[k] && $stable(dec_i[k]))
      else begin
        $error("slot %0d changed while stalled", k);
        fail_count++;
      end
  end

endmodule

bind decode_frontend decode_frontend_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush_i     (flush_i),
  .wr_valid_i  (wr_valid_i),
  .wr_ready_i  (wr_ready_o),
  .dec_valid_i (dec_valid_o),
  .dec_i       (dec_o),
  .dec_ready_i (dec_ready_i)
);

`default_nettype wire

// File: verif/decode_frontend_tb.sv
/*
 * decode front end testbench: random fetch stream with back-pressure
 * and flushes, per-slot decode and order checks
 */
`default_nettype none
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_frontend_tb
  import decode_pkg::*;
();

  localparam int          NUM_INSTR      = 400;
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 4 + 100;
  localparam logic [31:0] SEED           = 32'h6784cc33;
  localparam logic [31:0] BASE_PC        = 32'h1c00_0000;

  logic                             clk;
  logic                             rst_n;
  logic                             flush;
  logic                             wr_valid;
  logic [1:0]                       wr_num;
  fetch_entry_t [`FETCH_WIDTH-1:0]  wr_data;
  logic                             wr_ready;
  logic [`DECODE_WIDTH-1:0]         dec_valid;
  decoded_t [`DECODE_WIDTH-1:0]     dec;
  logic                             dec_ready;

  logic [31:0]  lfsr;
  logic [31:0]  wr_pc;
  logic [31:0]  exp_pc;
  int           exp_count;
  int           sent_cnt;
  int           flush_idx;
  int           cycle_cnt = 0;
  int           flush_at [2] = '{130, 270};
  fetch_entry_t sent_tab [bit [31:0]];

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  decode_frontend dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .wr_valid_i  (wr_valid),
    .wr_num_i    (wr_num),
    .wr_data_i   (wr_data),
    .wr_ready_o  (wr_ready),
    .dec_valid_o (dec_valid),
    .dec_o       (dec),
    .dec_ready_i (dec_ready)
  );

  // ============================================================
  // random source and reference rules
  // ============================================================
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [4:0] pick_src(src_type_e t, logic [31:0] w);
    case (t)
      SRC_RD:  return w[4:0];
      SRC_RJ:  return w[9:5];
      SRC_RK:  return w[14:10];
      default: return 5'd0;
    endcase
  endfunction

  function automatic logic [4:0] resolve_dest(dest_type_e t, logic [31:0] w);
    case (t)
      DEST_RD: return w[4:0];
      DEST_JD: return w[9:5] | w[4:0];
      DEST_RA: return `REG_RA;
      default: return 5'd0;
    endcase
  endfunction

  function automatic logic [31:0] extend_imm(imm_type_e t, logic [31:0] w, logic [31:0] pc);
    logic [31:0] si20;
    si20 = 32'($signed(w[24:5]));
    case (t)
      IMM_UI5:  return 32'(w[14:10]);
      IMM_UI12: return 32'(w[21:10]);
      IMM_SI12: return 32'($signed(w[21:10]));
      IMM_SI14: return 32'($signed(w[23:10]));
      IMM_SI16: return 32'($signed(w[25:10]));
      IMM_SI20: return si20;
      IMM_SI26: return 32'($signed({w[9:0], w[25:10]}));
      IMM_PC:   return pc + si20;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic priv_op_e refine_priv(priv_op_e p, logic [4:0] rj);
    if (p == PRIV_CSR_XCHG && rj == `CSR_RJ_READ) return PRIV_CSR_READ;
    if (p == PRIV_CSR_XCHG && rj == `CSR_RJ_WRITE) return PRIV_CSR_WRITE;
    if (p == PRIV_RDCNTVL && rj != 5'd0) return PRIV_RDCNTID;
    return p;
  endfunction

  // ============================================================
  // checking and stimulus
  // ============================================================
  task automatic report_fail();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic verify_slots();
    fetch_entry_t e;
    logic [31:0]  w;
    for (int k = 0; k < `DECODE_WIDTH; k++) begin
      if (dec_valid[k]) begin
        if (!sent_tab.exists(dec[k].pc)) begin
          $display("slot %0d shows pc %h, which was never written", k, dec[k].pc);
          report_fail();
        end else begin
          e = sent_tab[dec[k].pc];
          w = e.instr;
          compare_value($sformatf("dec_o[%0d].instr", k), dec[k].instr, w);
          compare_value($sformatf("dec_o[%0d].src0", k), 32'(dec[k].src0),
                        32'(pick_src(e.src0_type, w)));
          compare_value($sformatf("dec_o[%0d].src1", k), 32'(dec[k].src1),
                        32'(pick_src(e.src1_type, w)));
          compare_value($sformatf("dec_o[%0d].dest", k), 32'(dec[k].dest),
                        32'(resolve_dest(e.dest_type, w)));
          compare_value($sformatf("dec_o[%0d].imm", k), dec[k].imm,
                        extend_imm(e.imm_type, w, e.pc));
          compare_value($sformatf("dec_o[%0d].priv_op", k), 32'(dec[k].priv_op),
                        32'(refine_priv(e.priv_op, w[9:5])));
        end
      end
    end
  endtask

  task automatic make_entry(input logic [31:0] pc, output fetch_entry_t e);
    logic [31:0] r;
    e.pc = pc;
    take_bits(32, r);
    e.instr = r;
    take_bits(2, r);
    e.src0_type = src_type_e'(r[1:0]);
    take_bits(2, r);
    e.src1_type = src_type_e'(r[1:0]);
    take_bits(2, r);
    e.dest_type = dest_type_e'(r[1:0]);
    take_bits(4, r);
    e.imm_type = imm_type_e'(r[3:0] % 4'd9);
    take_bits(3, r);
    e.priv_op = priv_op_e'(r[2:0] % 3'd6);
    // steer rj onto the csr and counter codes now and then
    if (e.priv_op == PRIV_CSR_XCHG || e.priv_op == PRIV_RDCNTVL) begin
      take_bits(2, r);
      if (!r[1]) e.instr.reg_view.rj = {4'd0, r[0]};
    end
  endtask

  // one cycle from falling edge to falling edge
  task automatic run_cycle(input bit allow_write, input bit do_flush);
    fetch_entry_t e;
    logic [31:0]  r;
    logic [31:0]  v;
    int           n;
    int           pops;
    // occupancy as seen by the fetch and decode sides
    v = '0;
    for (int k = 0; k < `DECODE_WIDTH; k++) begin
      v[k] = exp_count > k;
    end
    compare_value("dec_valid_o", 32'(dec_valid), v);
    compare_value("wr_ready_o", 32'(wr_ready),
                  32'(`IBUF_DEPTH - exp_count >= `FETCH_WIDTH));
    verify_slots();
    take_bits(1, r);
    dec_ready = r[0] & ~do_flush;
    // entries shown while ready leave at the next edge
    pops = 0;
    for (int k = 0; k < `DECODE_WIDTH; k++) begin
      if (dec_ready && k < exp_count) begin
        compare_value($sformatf("dec_o[%0d].pc", k), dec[k].pc, exp_pc);
        exp_pc = exp_pc + 32'd4;
        pops++;
      end
    end
    n = 0;
    wr_valid = 1'b0;
    wr_data = '0;
    take_bits(1, r);
    if (allow_write && wr_ready && (r[0] || do_flush)) begin
      take_bits(1, r);
      n = (r[0] && sent_cnt < NUM_INSTR - 1) ? 2 : 1;
      for (int i = 0; i < n; i++) begin
        make_entry(wr_pc, e);
        sent_tab[wr_pc] = e;
        wr_data[i] = e;
        wr_pc = wr_pc + 32'd4;
      end
      wr_valid = 1'b1;
      wr_num = 2'(n);
      sent_cnt = sent_cnt + n;
    end
    flush = do_flush;
    // a flush empties the buffer and drops the write beside it
    exp_count = do_flush ? 0 : exp_count + n - pops;
    @(negedge clk);
  endtask

  // bound assertion failures and the cycle limit
  always @(negedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (dut_i.u_props.fail_count != 0) begin
      $display("a bound protocol assertion failed before %0t ns", $time);
      report_fail();
    end else if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_fail();
    end
  end

  initial begin
    flush = 1'b0;
    wr_valid = 1'b0;
    wr_num = 2'd1;
    wr_data = '0;
    dec_ready = 1'b0;
    lfsr = SEED;
    wr_pc = BASE_PC;
    exp_pc = BASE_PC;
    exp_count = 0;
    sent_cnt = 0;
    flush_idx = 0;
    @(posedge rst_n);
    @(negedge clk);
    compare_value("dec_valid_o", 32'(dec_valid), 32'd0);
    compare_value("wr_ready_o", 32'(wr_ready), 32'd1);

    while (sent_cnt < NUM_INSTR) begin
      if (flush_idx < 2 && sent_cnt >= flush_at[flush_idx]) begin
        run_cycle(1'b1, 1'b1);
        flush_idx++;
        wr_pc = BASE_PC + 32'(flush_idx) * 32'h0010_0000;
        exp_pc = wr_pc;
        compare_value("dec_valid_o", 32'(dec_valid), 32'd0);
        compare_value("wr_ready_o", 32'(wr_ready), 32'd1);
      end else begin
        run_cycle(1'b1, 1'b0);
      end
    end

    // drain until everything written since the last flush is consumed
    while (dec_valid != '0) begin
      run_cycle(1'b0, 1'b0);
    end
    compare_value("exp_pc", exp_pc, wr_pc);

    if (dut_i.u_props.fail_count != 0) begin
      $display("a bound protocol assertion failed during the run");
      report_fail();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/*
 * testbench clock and active-low reset source
 */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire
